// File: Makefile
VERILATOR := verilator
TOP := cpuTb
FILELIST := build.f
OBJ_DIR := obj_dir
LOG := sim.log
PASS_MSG := *** TEST PASSED ***

COMMON_FLAGS := --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS := --binary -Wno-fatal -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+include
src/cpuPkg.sv
src/aluUnit.sv
src/registerBank.sv
src/dataMemory.sv
src/instrMemory.sv
src/controlUnit.sv
src/cpuTop.sv
verification/cpuTb.sv

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ****************************************
// core sizing
// ****************************************

// number of architectural registers.
`define NUM_REGS 16

// instruction memory depth in 32-bit words.
`define IMEM_DEPTH 256

// data memory depth in 32-bit words.
`define DMEM_DEPTH 256

// trace records the sink can absorb before it returns a credit.
`define TRACE_CREDITS 4

`endif

// File: src/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input cpuPkg::aluOp_t aluOp,
	input cpuPkg::condCode_t cond,
	input cpuPkg::flags_t flagsIn,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flagsOut,
	output logic condMet
);
	import cpuPkg::*;

	logic [32:0] sum;
	logic [32:0] diff;
	logic carryOut;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // bit 32 is the borrow.

	always_comb begin
		carryOut = 1'b0;
		case (aluOp)
			ADD: {carryOut, result} = sum;
			SUB: {carryOut, result} = diff;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SHL: result = a << b[4:0]; // shift amount is the low five bits.
			SHR: result = a >> b[4:0];
			PASSB: result = b;
			default: result = b;
		endcase
	end

	assign flagsOut.zero = (result == '0);
	assign flagsOut.negative = result[31];
	assign flagsOut.carry = carryOut;

	// ****************************************
	// branch condition
	// ****************************************
	always_comb begin
		case (cond)
			ALWAYS: condMet = 1'b1;
			ZERO: condMet = flagsIn.zero;
			NOTZERO: condMet = !flagsIn.zero;
			NEG: condMet = flagsIn.negative;
			CARRY: condMet = flagsIn.carry;
			NEVER: condMet = 1'b0;
			default: condMet = 1'b0; // unused codes never branch.
		endcase
	end

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module controlUnit (
	input logic CLK,
	input logic rstN,
	input logic start,
	input cpuPkg::instrClass_t instrClass,
	input logic [4:0] op,
	input logic creditReturn,
	output cpuPkg::ctrlWord_t ctrl,
	output logic irWrite,
	output logic pcWrite,
	output logic traceValid,
	output logic halted
);
	import cpuPkg::*;

	localparam int CREDIT_W = $clog2(`TRACE_CREDITS + 1);

	cpuState_t state;
	cpuState_t nextState;
	ctrlWord_t ctrlReg;
	ctrlWord_t decoded;
	logic running;
	logic [CREDIT_W-1:0] credits;
	logic haveCredit;
	logic advance;

	// ****************************************
	// instruction decode
	// ****************************************
	always_comb begin
		decoded = CTRL_NOP;
		case (instrClass)
			ALU_REG, ALU_IMM: begin
				decoded.aluOp = aluOp_t'(op[2:0]);
				decoded.signExt = (instrClass == ALU_IMM);
				decoded.regWrite = 1'b1;
				decoded.flagWrite = 1'b1;
				decoded.traceOut = 1'b1;
			end
			MEMORY: begin
				decoded.aluOp = ADD; // address is ra plus the immediate.
				decoded.signExt = 1'b1;
				decoded.memWrite = op[4];
				decoded.regWrite = ~op[4];
				decoded.wbSel = WB_MEM;
				decoded.traceOut = ~op[4];
			end
			BRANCH: begin
				decoded.aluOp = PASSB;
				decoded.cond = condCode_t'(op[2:0]);
				decoded.signExt = 1'b1;
			end
			default: decoded = CTRL_NOP; // halt and unused classes do nothing.
		endcase
	end

	// ****************************************
	// sequencer
	// ****************************************
	assign haveCredit = (credits != '0);
	assign advance = !ctrlReg.traceOut || haveCredit; // records wait for a credit.

	always_comb begin
		nextState = state;
		case (state)
			FETCH: if (running) nextState = DECODE;
			DECODE: nextState = (instrClass == HALT) ? FETCH : EXECUTE;
			EXECUTE: nextState = WRITEBACK;
			WRITEBACK: if (advance) nextState = FETCH;
			default: nextState = FETCH;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= FETCH;
			running <= 1'b0;
			halted <= 1'b0;
			ctrlReg <= CTRL_NOP;
		end else begin
			state <= nextState;
			if (start && !halted)
				running <= 1'b1;
			if (state == DECODE) begin
				ctrlReg <= decoded; // held for execute and writeback.
				if (instrClass == HALT) begin
					running <= 1'b0;
					halted <= 1'b1;
				end
			end
		end
	end

	assign irWrite = (state == FETCH) && running;
	assign pcWrite = (state == WRITEBACK) && advance;
	assign traceValid = (state == WRITEBACK) && ctrlReg.traceOut && haveCredit;

	// enables fire only in the cycle that leaves writeback.
	always_comb begin
		ctrl = CTRL_NOP;
		if (state == EXECUTE || state == WRITEBACK) begin
			ctrl = ctrlReg;
			ctrl.regWrite = ctrlReg.regWrite && pcWrite;
			ctrl.flagWrite = ctrlReg.flagWrite && pcWrite;
			ctrl.memWrite = ctrlReg.memWrite && pcWrite;
		end
	end

	// ****************************************
	// trace credits
	// ****************************************
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			credits <= CREDIT_W'(`TRACE_CREDITS);
		end else begin
			case ({traceValid, creditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	aCreditBound: assert property (@(posedge CLK) disable iff (!rstN)
		credits <= CREDIT_W'(`TRACE_CREDITS))
		else $error("sink returned more credits than were granted.");

endmodule

// File: src/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] regIdx_t;
	typedef logic [7:0] pcAddr_t;
	typedef logic [7:0] dmAddr_t;

	typedef enum logic [2:0] {
		BRANCH  = 3'b000,
		ALU_REG = 3'b001,
		ALU_IMM = 3'b010,
		MEMORY  = 3'b100,
		HALT    = 3'b111
	} instrClass_t;

	typedef enum logic [2:0] {
		ADD, SUB, AND, OR, XOR, SHL, SHR, PASSB
	} aluOp_t;

	typedef enum logic [2:0] {
		ALWAYS, ZERO, NOTZERO, NEG, CARRY, NEVER
	} condCode_t;

	typedef struct packed {
		logic zero;
		logic negative;
		logic carry; // borrow for SUB.
	} flags_t;

	// writeback source select.
	localparam logic [1:0] WB_ALU = 2'b00;
	localparam logic [1:0] WB_MEM = 2'b01;

	typedef struct packed {
		aluOp_t aluOp;
		condCode_t cond;
		logic signExt; // second ALU operand is the sign-extended immediate.
		logic regWrite;
		logic flagWrite;
		logic memWrite;
		logic [1:0] wbSel;
		logic traceOut; // instruction commits a trace record.
	} ctrlWord_t;

	localparam ctrlWord_t CTRL_NOP = '{aluOp: ADD, cond: NEVER, signExt: 1'b0,
		regWrite: 1'b0, flagWrite: 1'b0, memWrite: 1'b0, wbSel: WB_ALU, traceOut: 1'b0};

	// rb occupies imm[15:12]; a store takes its data from rd.
	typedef struct packed {
		instrClass_t cls;
		logic [4:0] op;
		regIdx_t rd;
		regIdx_t ra;
		logic [15:0] imm;
	} instr_t;

	typedef struct packed {
		pcAddr_t pc;
		regIdx_t rd;
		word_t value;
	} trace_t;

	typedef enum logic [1:0] {
		FETCH     = 2'b00,
		DECODE    = 2'b01,
		EXECUTE   = 2'b11,
		WRITEBACK = 2'b10
	} cpuState_t;

endpackage

// File: src/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input logic CLK,
	input logic rstN,
	input logic start,
	input logic progWrite,
	input logic creditReturn,
	input cpuPkg::pcAddr_t progAddr,
	input cpuPkg::word_t progData,
	output cpuPkg::trace_t trace,
	output logic traceValid,
	output logic halted
);
	import cpuPkg::*;

	pcAddr_t pc;
	instr_t ir;
	flags_t flags;
	ctrlWord_t ctrl;
	logic irWrite;
	logic pcWrite;
	word_t fetched;
	word_t raData;
	word_t rbData;
	word_t immExt;
	word_t aluB;
	word_t aluResult;
	flags_t aluFlags;
	logic condMet;
	word_t memData;
	word_t wbData;
	regIdx_t rbIdx;

	// ****************************************
	// architectural state
	// ****************************************
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			flags <= '0;
		end else begin
			if (pcWrite)
				pc <= condMet ? ir.imm[7:0] : pc + 1'b1; // cond is NEVER off branches.
			if (ctrl.flagWrite)
				flags <= aluFlags;
		end
	end

	always_ff @(posedge CLK) begin
		if (irWrite)
			ir <= instr_t'(fetched);
	end

	// ****************************************
	// datapath
	// ****************************************
	assign immExt = {{16{ir.imm[15]}}, ir.imm};
	assign rbIdx = (ir.cls == MEMORY) ? ir.rd : ir.imm[15:12]; // stores read rd.
	assign aluB = ctrl.signExt ? immExt : rbData;
	assign wbData = (ctrl.wbSel == WB_MEM) ? memData : aluResult;

	assign trace.pc = pc;
	assign trace.rd = ir.rd;
	assign trace.value = wbData;

	controlUnit uControl (
		.CLK(CLK), .rstN(rstN), .start(start),
		.instrClass(ir.cls), .op(ir.op), .creditReturn(creditReturn),
		.ctrl(ctrl), .irWrite(irWrite), .pcWrite(pcWrite),
		.traceValid(traceValid), .halted(halted)
	);

	instrMemory uInstrMem (
		.CLK(CLK), .progWrite(progWrite), .progAddr(progAddr),
		.fetchAddr(pc), .progData(progData), .instr(fetched)
	);

	registerBank uRegs (
		.CLK(CLK), .rstN(rstN), .raIdx(ir.ra), .rbIdx(rbIdx),
		.wIdx(ir.rd), .wEn(ctrl.regWrite), .wData(wbData),
		.raData(raData), .rbData(rbData)
	);

	aluUnit uAlu (
		.a(raData), .b(aluB), .aluOp(ctrl.aluOp), .cond(ctrl.cond),
		.flagsIn(flags), .result(aluResult), .flagsOut(aluFlags), .condMet(condMet)
	);

	dataMemory uDataMem (
		.CLK(CLK), .addr(aluResult[$bits(dmAddr_t)-1:0]), .wEn(ctrl.memWrite),
		.wData(rbData), .rData(memData)
	);

endmodule

// File: src/dataMemory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module dataMemory (
	input logic CLK,
	input cpuPkg::dmAddr_t addr,
	input logic wEn,
	input cpuPkg::word_t wData,
	output cpuPkg::word_t rData
);
	import cpuPkg::*;

	word_t mem [`DMEM_DEPTH];

	// address settles in execute so the read is ready in writeback.
	always_ff @(posedge CLK) begin
		if (wEn)
			mem[addr] <= wData;
		rData <= mem[addr];
	end

endmodule

// File: src/instrMemory.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module instrMemory (
	input logic CLK,
	input logic progWrite,
	input cpuPkg::pcAddr_t progAddr,
	input cpuPkg::pcAddr_t fetchAddr,
	input cpuPkg::word_t progData,
	output cpuPkg::word_t instr
);
	import cpuPkg::*;

	word_t mem [`IMEM_DEPTH];

	always_ff @(posedge CLK) begin
		if (progWrite)
			mem[progAddr] <= progData; // program load before start.
	end

	assign instr = mem[fetchAddr]; // captured by the instruction register.

endmodule

// File: src/registerBank.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module registerBank (
	input logic CLK,
	input logic rstN,
	input cpuPkg::regIdx_t raIdx,
	input cpuPkg::regIdx_t rbIdx,
	input cpuPkg::regIdx_t wIdx,
	input logic wEn,
	input cpuPkg::word_t wData,
	output cpuPkg::word_t raData,
	output cpuPkg::word_t rbData
);
	import cpuPkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wEn) begin
			regs[wIdx] <= wData;
		end
	end

	// reads see the value before this cycle's write.
	assign raData = regs[raIdx];
	assign rbData = regs[rbIdx];

endmodule

// File: verification/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTb;
	import cpuPkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 6;
	localparam int SETUP_CYCLES = 60; // reset, program load and post-halt window of one test.
	localparam int TOTAL_INSTRS = 60;
	localparam int MAX_CREDIT_DELAY = 200;
	localparam int HOLD_CYCLES = 40;
	localparam int LIMIT_CYCLES = NUM_TESTS * SETUP_CYCLES + TOTAL_INSTRS * 4
		+ MAX_CREDIT_DELAY + HOLD_CYCLES + 200;

	logic CLK;
	logic rstN;
	logic start;
	logic progWrite;
	logic creditReturn = 1'b0;
	pcAddr_t progAddr;
	word_t progData;
	trace_t trace;
	logic traceValid;
	logic halted;

	integer seed = 32'h809b8b03;
	logic holdCredits = 1'b0;
	int outstanding = 0;
	word_t prog [$];
	trace_t expected [$];
	trace_t got [$];

	cpuTop DUT (
		.CLK(CLK), .rstN(rstN), .start(start), .progWrite(progWrite),
		.creditReturn(creditReturn), .progAddr(progAddr), .progData(progData),
		.trace(trace), .traceValid(traceValid), .halted(halted)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] want, input logic [31:0] seen);
		if (seen !== want) begin
			abortRun($sformatf("ERROR: %s expected 0x%h, got 0x%h", name, want, seen));
		end
	endtask

	// rb of a register-register instruction sits in imm[15:12].
	function automatic word_t encode(input logic [2:0] cls, input int op, input int rd,
		input int ra, input logic [15:0] imm);
		return {cls, op[4:0], rd[3:0], ra[3:0], imm};
	endfunction

	// ****************************************
	// sink and reference model
	// ****************************************
	always @(negedge CLK) begin
		if (!rstN) begin
			creditReturn = 1'b0;
			outstanding = 0;
		end else begin
			creditReturn = 1'b0;
			if (traceValid) begin
				if (outstanding >= `TRACE_CREDITS)
					abortRun("traceValid fired while every trace credit was in use");
				got.push_back(trace);
				outstanding++;
			end
			if (!holdCredits && outstanding > 0 && ($random(seed) & 1) == 1) begin
				creditReturn = 1'b1; // one credit back per pulse.
				outstanding--;
			end
		end
	end

	task automatic predictTrace();
		word_t regs [16];
		word_t mem [dmAddr_t];
		flags_t fl;
		int pc;
		bit done;
		word_t w;
		word_t a;
		word_t b;
		word_t ea;
		logic [32:0] wide;
		logic taken;
		trace_t rec;
		expected.delete();
		foreach (regs[i])
			regs[i] = '0;
		fl = '0;
		pc = 0;
		done = 1'b0;
		for (int step = 0; step < 256 && !done; step++) begin
			w = prog[pc];
			a = regs[w[19:16]];
			ea = a + {{16{w[15]}}, w[15:0]};
			rec.pc = pcAddr_t'(pc);
			rec.rd = w[23:20];
			case (instrClass_t'(w[31:29]))
				ALU_REG, ALU_IMM: begin
					b = (w[31:29] == ALU_IMM) ? {{16{w[15]}}, w[15:0]} : regs[w[15:12]];
					case (aluOp_t'(w[26:24]))
						ADD: wide = {1'b0, a} + {1'b0, b};
						SUB: wide = {1'b0, a} - {1'b0, b}; // bit 32 is the borrow.
						AND: wide = {1'b0, a & b};
						OR: wide = {1'b0, a | b};
						XOR: wide = {1'b0, a ^ b};
						SHL: wide = {1'b0, a << b[4:0]};
						SHR: wide = {1'b0, a >> b[4:0]};
						default: wide = {1'b0, b};
					endcase
					fl = '{zero: (wide[31:0] == '0), negative: wide[31], carry: wide[32]};
					regs[w[23:20]] = wide[31:0];
					rec.value = wide[31:0];
					expected.push_back(rec);
					pc++;
				end
				MEMORY: begin
					if (w[28]) begin
						mem[ea[7:0]] = regs[w[23:20]];
					end else begin
						regs[w[23:20]] = mem[ea[7:0]];
						rec.value = mem[ea[7:0]];
						expected.push_back(rec);
					end
					pc++;
				end
				BRANCH: begin
					case (condCode_t'(w[26:24]))
						ALWAYS: taken = 1'b1;
						ZERO: taken = fl.zero;
						NOTZERO: taken = !fl.zero;
						NEG: taken = fl.negative;
						CARRY: taken = fl.carry;
						default: taken = 1'b0;
					endcase
					pc = taken ? int'(w[7:0]) : pc + 1;
				end
				HALT: done = 1'b1;
				default: pc++;
			endcase
		end
	endtask

	// ****************************************
	// run control
	// ****************************************
	task automatic applyReset();
		@(negedge CLK);
		rstN = 1'b0;
		start = 1'b0;
		progWrite = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK);
		got.delete();
		rstN = 1'b1;
		@(negedge CLK);
		checkValue("traceValid after reset", 0, 32'(traceValid));
		checkValue("halted after reset", 0, 32'(halted));
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			@(negedge CLK);
			progWrite = 1'b1;
			progAddr = pcAddr_t'(i);
			progData = prog[i];
		end
		@(negedge CLK);
		progWrite = 1'b0;
	endtask

	task automatic startCore();
		@(negedge CLK);
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
	endtask

	task automatic waitForHalt();
		int seen;
		while (halted !== 1'b1)
			@(negedge CLK);
		seen = got.size();
		repeat (12) @(negedge CLK); // longer than any one instruction.
		checkValue("records after halt", 32'(seen), 32'(got.size()));
		checkValue("halted", 1, 32'(halted));
	endtask

	task automatic compareTrace();
		checkValue("record count", 32'(expected.size()), 32'(got.size()));
		foreach (expected[i]) begin
			checkValue($sformatf("trace.pc[%0d]", i), 32'(expected[i].pc), 32'(got[i].pc));
			checkValue($sformatf("trace.rd[%0d]", i), 32'(expected[i].rd), 32'(got[i].rd));
			checkValue($sformatf("trace.value[%0d]", i), expected[i].value, got[i].value);
		end
	endtask

	task automatic runProgram();
		loadProgram();
		predictTrace();
		startCore();
		waitForHalt();
		compareTrace();
	endtask

	// ****************************************
	// directed tests
	// ****************************************
	task automatic aluRegisterOps();
		applyReset();
		prog = {encode(ALU_IMM, PASSB, 1, 0, 16'h7a5c), encode(ALU_IMM, PASSB, 2, 0, 16'h0005),
			encode(ALU_REG, ADD, 3, 1, 16'h2000), encode(ALU_REG, SUB, 4, 2, 16'h1000),
			encode(ALU_REG, AND, 5, 1, 16'h2000), encode(ALU_REG, OR, 6, 1, 16'h2000),
			encode(ALU_REG, XOR, 7, 1, 16'h2000), encode(ALU_REG, SHL, 8, 1, 16'h2000),
			encode(ALU_REG, SHR, 9, 1, 16'h2000), encode(ALU_REG, PASSB, 10, 1, 16'h2000),
			encode(HALT, 0, 0, 0, 16'h0)};
		runProgram();
	endtask

	task automatic immediateOps();
		applyReset();
		prog = {encode(ALU_IMM, PASSB, 1, 0, 16'hfff0), encode(ALU_IMM, PASSB, 2, 0, 16'h8000),
			encode(ALU_IMM, ADD, 3, 1, 16'hffff), encode(ALU_IMM, SUB, 4, 2, 16'hfffe),
			encode(ALU_IMM, AND, 5, 1, 16'h00ff), encode(ALU_IMM, XOR, 6, 2, 16'hffff),
			encode(ALU_IMM, SHL, 7, 1, 16'h0004), encode(HALT, 0, 0, 0, 16'h0)};
		runProgram();
	endtask

	task automatic memoryRoundTrip();
		applyReset();
		prog = {encode(ALU_IMM, PASSB, 1, 0, 16'h0011), encode(ALU_IMM, PASSB, 2, 0, 16'hbeef),
			encode(ALU_IMM, PASSB, 3, 0, 16'h1357), encode(MEMORY, 5'h10, 2, 1, 16'h0000),
			encode(MEMORY, 5'h10, 3, 1, 16'h0005), encode(MEMORY, 5'h10, 1, 1, 16'hfffd),
			encode(MEMORY, 0, 4, 1, 16'h0000), encode(MEMORY, 0, 5, 1, 16'h0005),
			encode(MEMORY, 0, 6, 1, 16'hfffd), encode(HALT, 0, 0, 0, 16'h0)};
		runProgram();
	endtask

	// each skipped slot writes r9 so a wrong path shows up as an extra record.
	task automatic branchPaths();
		applyReset();
		prog = {encode(ALU_IMM, PASSB, 1, 0, 16'h0005), encode(ALU_IMM, SUB, 2, 1, 16'h0005),
			encode(BRANCH, ZERO, 0, 0, 16'd4), encode(ALU_IMM, PASSB, 9, 0, 16'h0bad),
			encode(BRANCH, NOTZERO, 0, 0, 16'd6), encode(ALU_IMM, SUB, 3, 1, 16'h0007),
			encode(BRANCH, NEG, 0, 0, 16'd8), encode(ALU_IMM, PASSB, 9, 0, 16'h0bad),
			encode(BRANCH, CARRY, 0, 0, 16'd10), encode(ALU_IMM, PASSB, 9, 0, 16'h0bad),
			encode(ALU_IMM, ADD, 4, 1, 16'hfffb), encode(BRANCH, NOTZERO, 0, 0, 16'd13),
			encode(BRANCH, CARRY, 0, 0, 16'd14), encode(ALU_IMM, PASSB, 9, 0, 16'h0bad),
			encode(BRANCH, ALWAYS, 0, 0, 16'd16), encode(ALU_IMM, PASSB, 9, 0, 16'h0bad),
			encode(ALU_IMM, PASSB, 5, 0, 16'h600d), encode(BRANCH, NEVER, 0, 0, 16'd15),
			encode(HALT, 0, 0, 0, 16'h0)};
		runProgram();
	endtask

	task automatic backPressure();
		applyReset();
		prog.delete();
		for (int i = 1; i <= 8; i++)
			prog.push_back(encode(ALU_IMM, ADD, i, i - 1, 16'(i * 16'h0123)));
		prog.push_back(encode(HALT, 0, 0, 0, 16'h0));
		loadProgram();
		predictTrace();
		@(posedge CLK);
		holdCredits = 1'b1;
		startCore();
		repeat (HOLD_CYCLES) @(negedge CLK); // long enough for the whole program without stalls.
		checkValue("records with credits held", `TRACE_CREDITS, 32'(got.size()));
		checkValue("halted with credits held", 0, 32'(halted));
		@(posedge CLK);
		holdCredits = 1'b0;
		waitForHalt();
		compareTrace();
	endtask

	task automatic haltAndReset();
		applyReset();
		prog = {encode(ALU_IMM, PASSB, 1, 0, 16'h0042), encode(HALT, 0, 0, 0, 16'h0),
			encode(ALU_IMM, PASSB, 2, 0, 16'h0099)};
		runProgram();
		applyReset();
	endtask

	initial begin
		rstN = 1'b0;
		start = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		aluRegisterOps();
		immediateOps();
		memoryRoundTrip();
		branchPaths();
		backPressure();
		haltAndReset();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge CLK);
		abortRun($sformatf("timeout after %0d cycles, the core stopped producing trace records",
			LIMIT_CYCLES));
	end

endmodule
